// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= tb_dec_exe
FILELIST ?= compile.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -Wno-fatal
SIM_ARGS ?= +verilator+error+limit+100

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) 2>&1 | tee $(LOG)
	grep -q "^Test OK$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== compile.f ====
core_pkg.sv
reg_file.sv
dec_stage.sv
dec_exe_latch.sv
mul_counter.sv
pipe_ctrl.sv
exe_stage.sv
dec_exe_top.sv
dec_exe_asserts.sv
tb_dec_exe.sv

// ==== core_pkg.sv ====
// Core widths, instruction encodings, opcode and controller enums, stage bundles
`default_nettype none

package core_pkg;

	localparam int XLEN = 32;
	localparam int REG_ADDR_W = 5;
	localparam int NUM_REGS = 32;
	localparam int INSTR_BYTES = 4; // Fall-through step for a not-taken branch

	localparam int MUL_STEPS = 4;
	localparam int MUL_BITS_PER_STEP = 8;
	localparam int MUL_CNT_W = $clog2(MUL_STEPS);

	// RV32 major opcodes and funct7 values of the supported subset
	localparam logic [6:0] OPC_OP = 7'b0110011;
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;
	localparam logic [6:0] F7_BASE = 7'b0000000;
	localparam logic [6:0] F7_SUB = 7'b0100000;
	localparam logic [6:0] F7_MULDIV = 7'b0000001;

	typedef enum logic [3:0] {
		OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLT,
		OP_ADDI, OP_MUL, OP_BEQ, OP_BNE, OP_NOP
	} opcode_e;

	typedef enum logic [1:0] {CTRL_RUN, CTRL_MUL, CTRL_FLUSH} ctrl_state_e;

	typedef enum logic {EXC_NONE, EXC_ILLEGAL} exc_e;

	typedef struct packed {
		logic valid;
		opcode_e op;
		logic [REG_ADDR_W-1:0] rd;
		logic [REG_ADDR_W-1:0] rs1;
		logic [REG_ADDR_W-1:0] rs2;
		logic wen;
		logic [XLEN-1:0] opa; // Register file values as read in decode
		logic [XLEN-1:0] opb;
		logic [XLEN-1:0] imm;
		logic [XLEN-1:0] pc;
		logic [XLEN-1:0] pred_pc;
		logic prediction;
		exc_e exc;
	} dec_exe_t;

	typedef struct packed {
		logic valid;
		logic [REG_ADDR_W-1:0] rd;
		logic [XLEN-1:0] data;
	} wb_t;

	typedef struct packed {
		logic valid;
		logic [XLEN-1:0] pc;
	} redirect_t;

	typedef struct packed {
		logic valid;
		exc_e cause;
		logic [XLEN-1:0] pc;
	} exc_rep_t;

endpackage

`default_nettype wire

// ==== dec_exe_asserts.sv ====
// Bound assertions on the stall, writeback, redirect and exception outputs of the slice
`timescale 1ns/1ps
`default_nettype none

module dec_exe_asserts import core_pkg::*; (
	input  logic clk_i,
	input  logic reset_i,
	input  logic stall_i,
	input  wb_t wb_i,
	input  redirect_t redirect_i,
	input  exc_rep_t exc_i
);

	int failures = 0;

	// The controller leaves reset in the run state
	stall_low_after_reset: assert property (@(posedge clk_i) $fell(reset_i) |-> !stall_i)
		else begin
			$error("stall_o high in the first cycle after reset");
			failures++;
		end

	redirect_one_cycle: assert property (@(posedge clk_i) disable iff (reset_i)
		redirect_i.valid |=> !redirect_i.valid)
		else begin
			$error("redirect_o.valid held for more than one cycle");
			failures++;
		end

	exc_one_cycle: assert property (@(posedge clk_i) disable iff (reset_i)
		exc_i.valid |=> !exc_i.valid)
		else begin
			$error("exc_o.valid held for more than one cycle");
			failures++;
		end

	wb_exc_exclusive: assert property (@(posedge clk_i) disable iff (reset_i)
		!(wb_i.valid && exc_i.valid))
		else begin
			$error("wb_o.valid and exc_o.valid high together"); // An illegal word must not write
			failures++;
		end

endmodule

bind dec_exe_top dec_exe_asserts u_asserts (
	.clk_i(clk_i),
	.reset_i(reset_i),
	.stall_i(stall_o),
	.wb_i(wb_o),
	.redirect_i(redirect_o),
	.exc_i(exc_o)
);

`default_nettype wire

// ==== dec_exe_latch.sv ====
// Decode to execute pipeline register with clear, kill and stall
`timescale 1ns/1ps
`default_nettype none

module dec_exe_latch import core_pkg::*; (
	input  logic clk_i,
	input  logic reset_i,
	input  logic kill_i,
	input  logic stall_i,
	input  dec_exe_t dec_i,
	output dec_exe_t exe_o
);

	dec_exe_t exe_q;

	// Kill wins over stall so a squashed slot never survives a held cycle
	always_ff @(posedge clk_i) begin
		if (reset_i || kill_i) begin
			exe_q <= '0;
		end else if (!stall_i) begin
			exe_q <= dec_i;
		end
	end

	assign exe_o = exe_q;

endmodule

`default_nettype wire

// ==== dec_exe_stimulus.txt ====
# I instr pc pred_pc pred_taken : instruction driven in order, all fields hex
# W rd data | R pc | X pc : expected writeback, redirect, exception in order, hex
I 00500093 00000000 00000004 0
W 01 00000005
I ffd00113 00000004 00000008 0
W 02 fffffffd
I 002081b3 00000008 0000000c 0
W 03 00000002
I 40118233 0000000c 00000010 0
W 04 fffffffd
I 001272b3 00000010 00000014 0
W 05 00000005
I 00326333 00000014 00000018 0
W 06 ffffffff
I 001343b3 00000018 0000001c 0
W 07 fffffffa
I 00122433 0000001c 00000020 0
W 08 00000001
I 0040a4b3 00000020 00000024 0
W 09 00000000
I 00708013 00000024 00000028 0
W 00 0000000c
I 00100533 00000028 0000002c 0
W 0a 00000005
I 12300593 0000002c 00000030 0
W 0b 00000123
I c1800613 00000030 00000034 0
W 0c fffffc18
I 02c586b3 00000034 00000038 0
W 0d fffb8f48
I 00168733 00000038 0000003c 0
W 0e fffb8f4d
I 00e6c7b3 0000003c 00000040 0
W 0f 00000005
I 00a08863 00000040 00000050 1
I 01000813 00000050 00000054 0
W 10 00000010
I 00a09463 00000054 00000058 0
I 00209c63 00000058 0000005c 0
R 00000070
I 06300a13 0000005c 00000060 0
I 06200a93 00000060 00000064 0
I 001a08b3 00000070 00000074 0
W 11 00000005
I 00208663 00000074 00000080 1
R 00000078
I 00100b13 00000080 00000084 0
I 00200b93 00000084 00000088 0
I ffffffff 00000078 0000007c 0
X 00000078
I 00a08463 0000007c 00000090 1
R 00000084
I 00300c13 00000090 00000094 0
I 00400c93 00000094 00000098 0
I 4020f1b3 00000084 00000088 0
X 00000084
I 00018933 00000088 0000008c 0
W 12 00000002
I 018b09b3 0000008c 00000090 0
W 13 00000000

// ==== dec_exe_top.sv ====
// Decode to execute slice top level
`timescale 1ns/1ps
`default_nettype none

module dec_exe_top import core_pkg::*; (
	input  logic clk_i,
	input  logic reset_i,
	input  logic fetch_valid_i,
	input  logic [XLEN-1:0] fetch_instr_i,
	input  logic [XLEN-1:0] fetch_pc_i,
	input  logic [XLEN-1:0] fetch_pred_pc_i,
	input  logic fetch_pred_taken_i,
	output logic stall_o,
	output wb_t wb_o,
	output redirect_t redirect_o,
	output exc_rep_t exc_o
);

	logic [REG_ADDR_W-1:0] rs1;
	logic [REG_ADDR_W-1:0] rs2;
	logic [XLEN-1:0] rdata1;
	logic [XLEN-1:0] rdata2;
	dec_exe_t dec_bundle;
	dec_exe_t exe_bundle;
	wb_t wb;
	logic mul_start;
	logic mul_busy;
	logic mul_last;
	logic mispredict;
	logic stall;
	logic kill;
	logic flush;

	reg_file u_reg_file (
		.clk_i(clk_i),
		.reset_i(reset_i),
		.rs1_i(rs1),
		.rs2_i(rs2),
		.wb_i(wb),
		.rdata1_o(rdata1),
		.rdata2_o(rdata2)
	);

	dec_stage u_dec_stage (
		.fetch_valid_i(fetch_valid_i),
		.fetch_instr_i(fetch_instr_i),
		.fetch_pc_i(fetch_pc_i),
		.fetch_pred_pc_i(fetch_pred_pc_i),
		.fetch_pred_taken_i(fetch_pred_taken_i),
		.flush_i(flush),
		.rdata1_i(rdata1),
		.rdata2_i(rdata2),
		.rs1_o(rs1),
		.rs2_o(rs2),
		.dec_o(dec_bundle)
	);

	dec_exe_latch u_dec_exe_latch (
		.clk_i(clk_i),
		.reset_i(reset_i),
		.kill_i(kill),
		.stall_i(stall),
		.dec_i(dec_bundle),
		.exe_o(exe_bundle)
	);

	exe_stage u_exe_stage (
		.clk_i(clk_i),
		.reset_i(reset_i),
		.exe_i(exe_bundle),
		.mul_busy_i(mul_busy),
		.mul_last_i(mul_last),
		.mul_start_o(mul_start),
		.mispredict_o(mispredict),
		.wb_o(wb),
		.redirect_o(redirect_o),
		.exc_o(exc_o)
	);

	mul_counter u_mul_counter (
		.clk_i(clk_i),
		.reset_i(reset_i),
		.start_i(mul_start),
		.busy_o(mul_busy),
		.last_o(mul_last)
	);

	pipe_ctrl u_pipe_ctrl (
		.clk_i(clk_i),
		.reset_i(reset_i),
		.mul_start_i(mul_start),
		.mul_last_i(mul_last),
		.mispredict_i(mispredict),
		.stall_o(stall),
		.kill_o(kill),
		.flush_o(flush)
	);

	assign stall_o = stall;
	assign wb_o = wb;

endmodule

`default_nettype wire

// ==== dec_stage.sv ====
// Instruction decoder producing the decode to execute bundle
`timescale 1ns/1ps
`default_nettype none

module dec_stage import core_pkg::*; (
	input  logic fetch_valid_i,
	input  logic [XLEN-1:0] fetch_instr_i,
	input  logic [XLEN-1:0] fetch_pc_i,
	input  logic [XLEN-1:0] fetch_pred_pc_i,
	input  logic fetch_pred_taken_i,
	input  logic flush_i,
	input  logic [XLEN-1:0] rdata1_i,
	input  logic [XLEN-1:0] rdata2_i,
	output logic [REG_ADDR_W-1:0] rs1_o,
	output logic [REG_ADDR_W-1:0] rs2_o,
	output dec_exe_t dec_o
);

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic [XLEN-1:0] imm_i;
	logic [XLEN-1:0] imm_b;
	logic [XLEN-1:0] imm;
	opcode_e op;
	logic legal;
	logic is_branch;

	assign opcode = fetch_instr_i[6:0];
	assign funct3 = fetch_instr_i[14:12];
	assign funct7 = fetch_instr_i[31:25];
	assign rs1_o = fetch_instr_i[19:15];
	assign rs2_o = fetch_instr_i[24:20];

	assign imm_i = {{20{fetch_instr_i[31]}}, fetch_instr_i[31:20]};
	assign imm_b = {{19{fetch_instr_i[31]}}, fetch_instr_i[31], fetch_instr_i[7],
		fetch_instr_i[30:25], fetch_instr_i[11:8], 1'b0};

	always_comb begin
		op = OP_NOP; // Anything not matched below stays a NOP and is flagged illegal
		imm = '0;
		case (opcode)
			OPC_OP: begin
				case ({funct7, funct3})
					{F7_BASE, 3'b000}: op = OP_ADD;
					{F7_SUB, 3'b000}: op = OP_SUB;
					{F7_BASE, 3'b111}: op = OP_AND;
					{F7_BASE, 3'b110}: op = OP_OR;
					{F7_BASE, 3'b100}: op = OP_XOR;
					{F7_BASE, 3'b010}: op = OP_SLT;
					{F7_MULDIV, 3'b000}: op = OP_MUL;
					default: op = OP_NOP;
				endcase
			end
			OPC_OP_IMM: begin
				imm = imm_i;
				if (funct3 == 3'b000) op = OP_ADDI;
			end
			OPC_BRANCH: begin
				imm = imm_b;
				if (funct3 == 3'b000) op = OP_BEQ;
				else if (funct3 == 3'b001) op = OP_BNE;
			end
			default: op = OP_NOP;
		endcase
	end

	assign legal = op != OP_NOP;
	assign is_branch = op == OP_BEQ || op == OP_BNE;

	always_comb begin
		dec_o.valid = fetch_valid_i && !flush_i; // Input presented during a flush is dropped
		dec_o.op = op;
		dec_o.rd = fetch_instr_i[11:7];
		dec_o.rs1 = rs1_o;
		dec_o.rs2 = rs2_o;
		dec_o.wen = legal && !is_branch;
		dec_o.opa = rdata1_i;
		dec_o.opb = rdata2_i;
		dec_o.imm = imm;
		dec_o.pc = fetch_pc_i;
		dec_o.pred_pc = fetch_pred_pc_i;
		dec_o.prediction = fetch_pred_taken_i;
		dec_o.exc = legal ? EXC_NONE : EXC_ILLEGAL;
	end

endmodule

`default_nettype wire

// ==== exe_stage.sv ====
// Execute stage with ALU, forwarding, iterative multiply, branch resolution and result registers
`timescale 1ns/1ps
`default_nettype none

module exe_stage import core_pkg::*; (
	input  logic clk_i,
	input  logic reset_i,
	input  dec_exe_t exe_i,
	input  logic mul_busy_i,
	input  logic mul_last_i,
	output logic mul_start_o,
	output logic mispredict_o,
	output wb_t wb_o,
	output redirect_t redirect_o,
	output exc_rep_t exc_o
);

	wb_t wb_q;
	redirect_t redirect_q;
	exc_rep_t exc_q;
	logic [XLEN-1:0] opa;
	logic [XLEN-1:0] opb;
	logic [XLEN-1:0] alu_res;
	logic [XLEN-1:0] br_target;
	logic [XLEN-1:0] mul_step;
	logic [XLEN-1:0] mul_acc_q;
	logic [XLEN-1:0] mul_cand_q;
	logic [XLEN-1:0] mul_plier_q;
	logic [REG_ADDR_W-1:0] mul_rd_q;
	logic issue;
	logic is_branch;
	logic taken;

	assign issue = exe_i.valid && !mul_busy_i; // Held while a multiply owns the datapath

	// Result written last cycle has not reached the register file yet
	assign opa = (wb_q.valid && wb_q.rd != '0 && wb_q.rd == exe_i.rs1) ? wb_q.data : exe_i.opa;
	assign opb = (wb_q.valid && wb_q.rd != '0 && wb_q.rd == exe_i.rs2) ? wb_q.data : exe_i.opb;

	always_comb begin
		case (exe_i.op)
			OP_ADD: alu_res = opa + opb;
			OP_SUB: alu_res = opa - opb;
			OP_AND: alu_res = opa & opb;
			OP_OR: alu_res = opa | opb;
			OP_XOR: alu_res = opa ^ opb;
			OP_SLT: alu_res = XLEN'($signed(opa) < $signed(opb));
			OP_ADDI: alu_res = opa + exe_i.imm;
			default: alu_res = '0;
		endcase
	end

	assign is_branch = exe_i.op == OP_BEQ || exe_i.op == OP_BNE;
	assign taken = (exe_i.op == OP_BEQ) ? (opa == opb) : (opa != opb);
	assign br_target = taken ? exe_i.pc + exe_i.imm : exe_i.pc + XLEN'(INSTR_BYTES);
	assign mispredict_o = issue && is_branch &&
		(taken != exe_i.prediction || (taken && br_target != exe_i.pred_pc));

	// Shift and add, one multiplier byte per busy cycle
	assign mul_start_o = issue && exe_i.op == OP_MUL;
	assign mul_step = mul_acc_q + mul_cand_q * XLEN'(mul_plier_q[MUL_BITS_PER_STEP-1:0]);

	always_ff @(posedge clk_i) begin
		if (mul_start_o) begin
			mul_acc_q <= '0;
			mul_cand_q <= opa;
			mul_plier_q <= opb;
			mul_rd_q <= exe_i.rd;
		end else if (mul_busy_i) begin
			mul_acc_q <= mul_step;
			mul_cand_q <= mul_cand_q << MUL_BITS_PER_STEP;
			mul_plier_q <= mul_plier_q >> MUL_BITS_PER_STEP;
		end
	end

	always_ff @(posedge clk_i) begin
		wb_q.rd <= mul_last_i ? mul_rd_q : exe_i.rd;
		wb_q.data <= mul_last_i ? mul_step : alu_res;
		redirect_q.pc <= br_target;
		exc_q.cause <= exe_i.exc;
		exc_q.pc <= exe_i.pc;
		if (reset_i) begin
			wb_q.valid <= 1'b0;
			redirect_q.valid <= 1'b0;
			exc_q.valid <= 1'b0;
		end else begin
			wb_q.valid <= mul_last_i || (issue && exe_i.wen && exe_i.op != OP_MUL);
			redirect_q.valid <= mispredict_o;
			exc_q.valid <= issue && exe_i.exc == EXC_ILLEGAL;
		end
	end

	assign wb_o = wb_q;
	assign redirect_o = redirect_q;
	assign exc_o = exc_q;

endmodule

`default_nettype wire

// ==== mul_counter.sv ====
// Step counter for the iterative multiplier
`timescale 1ns/1ps
`default_nettype none

module mul_counter import core_pkg::*; (
	input  logic clk_i,
	input  logic reset_i,
	input  logic start_i,
	output logic busy_o,
	output logic last_o
);

	logic [MUL_CNT_W-1:0] cnt_q;
	logic busy_q;

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			busy_q <= 1'b0;
			cnt_q <= '0;
		end else if (start_i) begin
			busy_q <= 1'b1;
			cnt_q <= MUL_CNT_W'(MUL_STEPS - 1);
		end else if (busy_q) begin
			if (cnt_q == '0) begin
				busy_q <= 1'b0; // Final step done
			end else begin
				cnt_q <= cnt_q - 1'b1;
			end
		end
	end

	assign busy_o = busy_q;
	assign last_o = busy_q && cnt_q == '0;

endmodule

`default_nettype wire

// ==== pipe_ctrl.sv ====
// Pipeline controller FSM for stall, kill and flush
`timescale 1ns/1ps
`default_nettype none

module pipe_ctrl import core_pkg::*; (
	input  logic clk_i,
	input  logic reset_i,
	input  logic mul_start_i,
	input  logic mul_last_i,
	input  logic mispredict_i,
	output logic stall_o,
	output logic kill_o,
	output logic flush_o
);

	ctrl_state_e state_q;
	ctrl_state_e state_d;

	always_comb begin
		state_d = state_q;
		case (state_q)
			CTRL_RUN: begin
				if (mul_start_i) begin
					state_d = CTRL_MUL;
				end else if (mispredict_i) begin
					state_d = CTRL_FLUSH;
				end
			end
			CTRL_MUL: begin
				if (mul_last_i) state_d = CTRL_RUN;
			end
			CTRL_FLUSH: state_d = CTRL_RUN; // One bubble while the redirect goes out
			default: state_d = CTRL_RUN;
		endcase
	end

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			state_q <= CTRL_RUN;
		end else begin
			state_q <= state_d;
		end
	end

	assign stall_o = state_q == CTRL_MUL;
	assign flush_o = state_q == CTRL_FLUSH;

	// The younger instruction in decode is squashed at the resolving edge
	assign kill_o = mispredict_i;

endmodule

`default_nettype wire

// ==== reg_file.sv ====
// Integer register file with x0 tied to zero and write-through reads
`timescale 1ns/1ps
`default_nettype none

module reg_file import core_pkg::*; (
	input  logic clk_i,
	input  logic reset_i,
	input  logic [REG_ADDR_W-1:0] rs1_i,
	input  logic [REG_ADDR_W-1:0] rs2_i,
	input  wb_t wb_i,
	output logic [XLEN-1:0] rdata1_o,
	output logic [XLEN-1:0] rdata2_o
);

	logic [XLEN-1:0] regs [NUM_REGS];

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wb_i.valid && wb_i.rd != '0) begin
			regs[wb_i.rd] <= wb_i.data;
		end
	end

	// A result written this cycle is returned to the instruction being decoded
	assign rdata1_o = (rs1_i == '0) ? '0 :
		(wb_i.valid && wb_i.rd == rs1_i) ? wb_i.data : regs[rs1_i];
	assign rdata2_o = (rs2_i == '0) ? '0 :
		(wb_i.valid && wb_i.rd == rs2_i) ? wb_i.data : regs[rs2_i];

endmodule

`default_nettype wire

// ==== tb_dec_exe.sv ====
// Testbench for the decode to execute slice, driven and checked from a stimulus file
`timescale 1ns/1ps
`default_nettype none

module tb_dec_exe import core_pkg::*; ();

	localparam string STIM_FILE = "dec_exe_stimulus.txt";
	localparam int DRIVE_LIMIT = 50;
	localparam int DRAIN_LIMIT = 200;

	logic clk_i;
	logic reset_i;
	logic fetch_valid_i;
	logic [XLEN-1:0] fetch_instr_i;
	logic [XLEN-1:0] fetch_pc_i;
	logic [XLEN-1:0] fetch_pred_pc_i;
	logic fetch_pred_taken_i;
	logic stall_o;
	wb_t wb_o;
	redirect_t redirect_o;
	exc_rep_t exc_o;

	logic [XLEN-1:0] instr_q [$];
	logic [XLEN-1:0] pc_q [$];
	logic [XLEN-1:0] pred_pc_q [$];
	logic taken_q [$];
	byte exp_kind [$];
	logic [XLEN-1:0] exp_a [$];
	logic [XLEN-1:0] exp_b [$];
	int exp_idx = 0;
	int mul_count = 0;
	int stall_run = 0;
	int stall_runs = 0;

	dec_exe_top uut (
		.clk_i(clk_i),
		.reset_i(reset_i),
		.fetch_valid_i(fetch_valid_i),
		.fetch_instr_i(fetch_instr_i),
		.fetch_pc_i(fetch_pc_i),
		.fetch_pred_pc_i(fetch_pred_pc_i),
		.fetch_pred_taken_i(fetch_pred_taken_i),
		.stall_o(stall_o),
		.wb_o(wb_o),
		.redirect_o(redirect_o),
		.exc_o(exc_o)
	);

	always #4 clk_i = ~clk_i;

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("Test FAILED");
		$fatal(1);
	endtask

	task automatic check_value(input string what, input logic [XLEN-1:0] got,
		input logic [XLEN-1:0] exp);
		if (got !== exp) begin
			abort_run($sformatf("[FAIL] %0t ns: %s is %h, expected %h", $time, what, got, exp));
		end
	endtask

	task automatic read_stimulus();
		int fd;
		int n;
		string line;
		byte kind;
		logic [XLEN-1:0] f1;
		logic [XLEN-1:0] f2;
		logic [XLEN-1:0] f3;
		logic [XLEN-1:0] f4;
		fd = $fopen(STIM_FILE, "r");
		if (fd == 0) begin
			abort_run({"Could not open the stimulus file ", STIM_FILE});
		end else begin
			while (!$feof(fd)) begin
				line = "";
				n = $fgets(line, fd);
				if (n > 1 && line[0] != "#") begin
					kind = line[0];
					f2 = '0;
					n = $sscanf(line.substr(1, line.len() - 1), "%h %h %h %h", f1, f2, f3, f4);
					case (kind)
						"I": begin
							instr_q.push_back(f1);
							pc_q.push_back(f2);
							pred_pc_q.push_back(f3);
							taken_q.push_back(f4[0]);
							// Every MUL in the list is on the right path and stalls once
							if (f1[6:0] == 7'b0110011 && f1[31:25] == 7'b0000001) mul_count++;
						end
						"W", "R", "X": begin
							exp_kind.push_back(kind);
							exp_a.push_back(f1);
							exp_b.push_back(kind == "W" ? f2 : '0);
						end
						default: abort_run({"Stimulus line not understood: ", line});
					endcase
				end
			end
			$fclose(fd);
		end
	endtask

	// Presents one instruction and holds it until an edge with stall_o low
	task automatic drive_instr(input int k);
		int cycles;
		cycles = 0;
		fetch_valid_i <= 1'b1;
		fetch_instr_i <= instr_q[k];
		fetch_pc_i <= pc_q[k];
		fetch_pred_pc_i <= pred_pc_q[k];
		fetch_pred_taken_i <= taken_q[k];
		do begin
			@(posedge clk_i);
			cycles++;
		end while (stall_o && cycles < DRIVE_LIMIT);
		if (stall_o) begin
			abort_run($sformatf("Instruction at pc %h was never accepted, stall_o stuck high",
				pc_q[k]));
		end
	endtask

	task automatic match_event(input byte kind, input logic [XLEN-1:0] a,
		input logic [XLEN-1:0] b);
		if (exp_idx >= exp_kind.size()) begin
			abort_run($sformatf("Unexpected %c event at %0t ns after all expected events",
				kind, $time));
		end else begin
			check_value($sformatf("kind of event %0d", exp_idx), XLEN'(kind),
				XLEN'(exp_kind[exp_idx]));
			check_value($sformatf("first field of event %0d (%c)", exp_idx, kind), a,
				exp_a[exp_idx]);
			if (kind == "W") begin // Only a writeback carries data
				check_value($sformatf("second field of event %0d (%c)", exp_idx, kind), b,
					exp_b[exp_idx]);
			end
			exp_idx++;
		end
	endtask

	// Outputs are registered, so the falling edge sees them settled
	always @(negedge clk_i) begin
		if (!reset_i) begin
			if (wb_o.valid) match_event("W", XLEN'(wb_o.rd), wb_o.data);
			if (redirect_o.valid) match_event("R", redirect_o.pc, '0);
			if (exc_o.valid) begin
				check_value("exception cause", XLEN'(exc_o.cause), XLEN'(EXC_ILLEGAL));
				match_event("X", exc_o.pc, '0);
			end
			if (stall_o) begin
				stall_run++;
			end else if (stall_run != 0) begin
				check_value("cycles with stall_o high", stall_run, MUL_STEPS);
				stall_runs++;
				stall_run = 0;
			end
		end
	end

	initial begin
		int cycles;
		clk_i = 1'b0;
		reset_i = 1'b1;
		fetch_valid_i = 1'b0;
		fetch_instr_i = '0;
		fetch_pc_i = '0;
		fetch_pred_pc_i = '0;
		fetch_pred_taken_i = 1'b0;
		read_stimulus();
		repeat (4) @(posedge clk_i);
		reset_i <= 1'b0;
		for (int k = 0; k < instr_q.size(); k++) begin
			drive_instr(k);
		end
		fetch_valid_i <= 1'b0;
		cycles = 0;
		while (exp_idx < exp_kind.size() && cycles < DRAIN_LIMIT) begin
			@(posedge clk_i);
			cycles++;
		end
		repeat (8) @(posedge clk_i); // Window for stray events after the last one
		check_value("number of multiply stalls", stall_runs, mul_count);
		check_value("assertion failures", uut.u_asserts.failures, 0);
		if (exp_idx == exp_kind.size()) begin
			$display("Test OK");
			$finish;
		end else begin
			abort_run($sformatf("Timed out with %0d of %0d expected events seen",
				exp_idx, exp_kind.size()));
		end
	end

endmodule

`default_nettype wire
